/* Makefile */
SRCS = secsub_pkg.sv bus_upsizer.sv bus_isolate.sv secure_subsystem_wrap.sv \
       tb_secure_subsystem.sv

.PHONY: run clean

run: obj_dir/Vtb_secure_subsystem secsub_testdata.txt
	./obj_dir/Vtb_secure_subsystem | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

obj_dir/Vtb_secure_subsystem: $(SRCS) tb.f
	verilator --binary --timing --assert --top-module tb_secure_subsystem \
		-f tb.f -o Vtb_secure_subsystem

clean:
	rm -rf obj_dir sim.log

/* bus_isolate.sv */
// Outbound bus isolation gate
// Synchronizes the isolate request, waits for outstanding writes to
// drain, then answers new writes locally with an error response.
// In the running state requests pass straight through.

`timescale 1ns/1ns

module bus_isolate (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   isolate_i,
   // Wide request from the upsizer
   input  logic                   up_valid_i,
   input  secsub_pkg::addr_t      up_addr_i,
   input  secsub_pkg::wide_data_t up_data_i,
   input  secsub_pkg::wide_strb_t up_strb_i,
   output logic                   up_ready_o,
   // Outbound request
   output logic                   out_valid_o,
   output secsub_pkg::addr_t      out_addr_o,
   output secsub_pkg::wide_data_t out_data_o,
   output secsub_pkg::wide_strb_t out_strb_o,
   input  logic                   out_ready_i,
   // Write response, downstream and upstream
   input  logic                   rsp_valid_i,
   input  logic                   rsp_err_i,
   output logic                   rsp_valid_o,
   output logic                   rsp_err_o,
   output logic                   isolated_o
);

   typedef enum logic [1:0] {
      RUN,
      DRAIN,
      ISOLATED
   } state_t;

   localparam secsub_pkg::pend_cnt_t PEND_MAX = secsub_pkg::pend_cnt_t'(secsub_pkg::MAX_PENDING);

   state_t                         state_q;
   state_t                         state_d;
   logic [secsub_pkg::SYNC_STAGES-1:0] sync_q;
   logic                           iso_sync;
   secsub_pkg::pend_cnt_t          pend_q;
   logic                           pend_full;
   logic                           fwd_fire;
   logic                           term_fire;
   logic                           err_rsp_q;

   // Isolate request synchronizer, comes up isolated
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sync_q <= '1;
      end else begin
         sync_q <= {sync_q[secsub_pkg::SYNC_STAGES-2:0], isolate_i};
      end
   end

   assign iso_sync  = sync_q[secsub_pkg::SYNC_STAGES-1];
   assign pend_full = (pend_q == PEND_MAX);

   // Request path
   assign out_valid_o = (state_q == RUN) && up_valid_i && !pend_full;
   assign out_addr_o  = up_addr_i;
   assign out_data_o  = up_data_i;
   assign out_strb_o  = up_strb_i;

   always_comb begin
      case (state_q)
         RUN:      up_ready_o = out_ready_i && !pend_full;
         ISOLATED: up_ready_o = 1'b1;
         default:  up_ready_o = 1'b0;
      endcase
   end

   assign fwd_fire  = out_valid_o && out_ready_i;
   assign term_fire = (state_q == ISOLATED) && up_valid_i;

   // Outstanding forwarded writes
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pend_q <= '0;
      end else if (fwd_fire && !rsp_valid_i) begin
         pend_q <= pend_q + secsub_pkg::pend_cnt_t'(1);
      end else if (!fwd_fire && rsp_valid_i) begin
         pend_q <= pend_q - secsub_pkg::pend_cnt_t'(1);
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         // Leave only when no write is stalled on the outbound port
         RUN:      if (iso_sync && !(out_valid_o && !out_ready_i)) state_d = DRAIN;
         DRAIN:    if (pend_q == '0) state_d = ISOLATED;
         ISOLATED: if (!iso_sync) state_d = RUN;
         default:  state_d = ISOLATED;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q   <= ISOLATED;
         err_rsp_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         err_rsp_q <= term_fire;
      end
   end

   // Terminated writes answer one cycle after acceptance
   assign rsp_valid_o = rsp_valid_i || err_rsp_q;
   assign rsp_err_o   = err_rsp_q || rsp_err_i;
   assign isolated_o  = (state_q == ISOLATED);

   pend_limit_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      pend_q <= PEND_MAX
   ) else $error("pending write count above limit");

   no_fwd_when_blocked_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      out_valid_o |-> state_q == RUN
   ) else $error("outbound write outside the running state");

endmodule

/* bus_upsizer.sv */
// Narrow-to-wide write upsizer
// One-entry pipeline register that places a 32-bit write into its lane
// of the 64-bit outbound bus, selected by address bit 2

`timescale 1ns/1ns

module bus_upsizer (
   input  logic                     clk_i,
   input  logic                     rst_i,
   // Narrow request from the subsystem
   input  logic                     req_valid_i,
   input  secsub_pkg::addr_t        req_addr_i,
   input  secsub_pkg::narrow_data_t req_data_i,
   input  secsub_pkg::narrow_strb_t req_strb_i,
   output logic                     req_ready_o,
   // Wide request towards the isolation gate
   output logic                     up_valid_o,
   output secsub_pkg::addr_t        up_addr_o,
   output secsub_pkg::wide_data_t   up_data_o,
   output secsub_pkg::wide_strb_t   up_strb_o,
   input  logic                     up_ready_i
);

   logic                   valid_q;
   secsub_pkg::addr_t      addr_q;
   secsub_pkg::wide_data_t data_q;
   secsub_pkg::wide_strb_t strb_q;

   secsub_pkg::wide_data_t data_d;
   secsub_pkg::wide_strb_t strb_d;
   logic                   accept;
   logic                   upper_lane;

   // Free slot, or the held entry leaves this cycle
   assign req_ready_o = !valid_q || up_ready_i;
   assign accept      = req_valid_i && req_ready_o;

   assign upper_lane = req_addr_i[2];

   // Data goes to both halves, strobe only to the addressed one
   assign data_d = {req_data_i, req_data_i};
   assign strb_d = upper_lane ? {req_strb_i, secsub_pkg::narrow_strb_t'(0)}
                              : {secsub_pkg::narrow_strb_t'(0), req_strb_i};

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else if (accept) begin
         valid_q <= 1'b1;
      end else if (up_ready_i) begin
         valid_q <= 1'b0;
      end
   end

   // Payload only moves on an accepted write
   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q <= req_addr_i;
         data_q <= data_d;
         strb_q <= strb_d;
      end
   end

   assign up_valid_o = valid_q;
   assign up_addr_o  = addr_q;
   assign up_data_o  = data_q;
   assign up_strb_o  = strb_q;

   // Held entry stays put until the gate takes it
   hold_under_stall_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      up_valid_o && !up_ready_i |=>
         up_valid_o && $stable(up_addr_o) && $stable(up_data_o) && $stable(up_strb_o)
   ) else $error("upsizer output changed under back-pressure");

endmodule

/* secsub_pkg.sv */
// Secure subsystem outbound bus definitions
// Bus widths, isolate synchronizer depth, pending-write limit and the
// vector types shared by the upsizer, the isolation gate and the top level

package secsub_pkg;

   // Bus geometry
   localparam int unsigned ADDR_W        = 32;
   localparam int unsigned NARROW_DATA_W = 32;
   localparam int unsigned WIDE_DATA_W   = 64;

   // Isolation gate
   localparam int unsigned SYNC_STAGES   = 3;
   localparam int unsigned MAX_PENDING   = 8;

   // Byte strobe widths follow the data widths
   localparam int unsigned NARROW_STRB_W = NARROW_DATA_W / 8;
   localparam int unsigned WIDE_STRB_W   = WIDE_DATA_W / 8;

   // Wide enough for 0 to MAX_PENDING inclusive
   localparam int unsigned PEND_CNT_W    = $clog2(MAX_PENDING + 1);

   typedef logic [ADDR_W-1:0]        addr_t;
   typedef logic [NARROW_DATA_W-1:0] narrow_data_t;
   typedef logic [NARROW_STRB_W-1:0] narrow_strb_t;
   typedef logic [WIDE_DATA_W-1:0]   wide_data_t;
   typedef logic [WIDE_STRB_W-1:0]   wide_strb_t;
   typedef logic [PEND_CNT_W-1:0]    pend_cnt_t;

endpackage

/* secsub_testdata.txt */
# cmd addr data strb wide_strb  (W = narrow write, I = isolate level in the addr column)
# wide_strb is the narrow strobe moved to the half selected by address bit 2
W 00001000 11111111 f 0f
W 00001004 22222222 f f0
W 00001008 33333333 3 03
W 0000100c 44444444 c c0
W 20000010 a5a5a5a5 1 01
W 20000014 5a5a5a5a 8 80
W 20000018 deadbeef 6 06
W 2000001c cafef00d 9 90
W 80000020 01234567 f 0f
W 80000024 89abcdef f f0
W 80000028 00000000 0 00
W 8000002c ffffffff 5 50
I 1 0 0 00
W 00002000 badc0de1 f 0f
W 00002004 badc0de2 f f0
W 00002008 badc0de3 3 03
W 0000200c badc0de4 c c0
I 0 0 0 00
W 40000100 13579bdf f 0f
W 40000104 2468ace0 a a0
W 40000108 0f0f0f0f 2 02
W 4000010c f0f0f0f0 4 40
W 40000110 76543210 f 0f
W 40000114 fedcba98 7 70
I 1 0 0 00
W 00003000 0bad0bad f 0f
W 00003004 0bad0bad 1 10
I 0 0 0 00
W 10000040 aaaa5555 f 0f
W 10000044 5555aaaa f f0
W 10000048 c3c3c3c3 b 0b
W 1000004c 3c3c3c3c d d0
W fffffff8 87654321 f 0f
W fffffffc 12345678 e e0

/* secure_subsystem_wrap.sv */
// Secure subsystem outbound write path
// Narrow writes from the subsystem are upsized onto the 64-bit bus in a
// registered stage, then pass through the isolation gate to the outside

`timescale 1ns/1ns

module secure_subsystem_wrap (
   input  logic                     clk_i,
   input  logic                     rst_i,
   // Isolation control
   input  logic                     isolate_i,
   output logic                     isolated_o,
   // Narrow write request
   input  logic                     req_valid_i,
   input  secsub_pkg::addr_t        req_addr_i,
   input  secsub_pkg::narrow_data_t req_data_i,
   input  secsub_pkg::narrow_strb_t req_strb_i,
   output logic                     req_ready_o,
   // Outbound wide write request
   output logic                     out_valid_o,
   output secsub_pkg::addr_t        out_addr_o,
   output secsub_pkg::wide_data_t   out_data_o,
   output secsub_pkg::wide_strb_t   out_strb_o,
   input  logic                     out_ready_i,
   // Write response
   input  logic                     rsp_valid_i,
   input  logic                     rsp_err_i,
   output logic                     rsp_valid_o,
   output logic                     rsp_err_o
);

   // Upsizer to gate
   logic                   up_valid;
   logic                   up_ready;
   secsub_pkg::addr_t      up_addr;
   secsub_pkg::wide_data_t up_data;
   secsub_pkg::wide_strb_t up_strb;

   bus_upsizer upsizer_i (
      .clk_i       ( clk_i       ),
      .rst_i       ( rst_i       ),
      .req_valid_i ( req_valid_i ),
      .req_addr_i  ( req_addr_i  ),
      .req_data_i  ( req_data_i  ),
      .req_strb_i  ( req_strb_i  ),
      .req_ready_o ( req_ready_o ),
      .up_valid_o  ( up_valid    ),
      .up_addr_o   ( up_addr     ),
      .up_data_o   ( up_data     ),
      .up_strb_o   ( up_strb     ),
      .up_ready_i  ( up_ready    )
   );

   bus_isolate isolate_i_inst (
      .clk_i       ( clk_i       ),
      .rst_i       ( rst_i       ),
      .isolate_i   ( isolate_i   ),
      .up_valid_i  ( up_valid    ),
      .up_addr_i   ( up_addr     ),
      .up_data_i   ( up_data     ),
      .up_strb_i   ( up_strb     ),
      .up_ready_o  ( up_ready    ),
      .out_valid_o ( out_valid_o ),
      .out_addr_o  ( out_addr_o  ),
      .out_data_o  ( out_data_o  ),
      .out_strb_o  ( out_strb_o  ),
      .out_ready_i ( out_ready_i ),
      .rsp_valid_i ( rsp_valid_i ),
      .rsp_err_i   ( rsp_err_i   ),
      .rsp_valid_o ( rsp_valid_o ),
      .rsp_err_o   ( rsp_err_o   ),
      .isolated_o  ( isolated_o  )
   );

endmodule

/* tb.f */
secsub_pkg.sv
bus_upsizer.sv
bus_isolate.sv
secure_subsystem_wrap.sv
tb_secure_subsystem.sv

/* tb_secure_subsystem.sv */
// Testbench for the secure subsystem outbound write path
// Replays write and isolate commands from the testdata file, models the
// downstream slave with random back-pressure and fixed-latency responses,
// and checks lane placement, ordering, draining and error termination

`timescale 1ns/1ns

module tb_secure_subsystem;

   logic                     clk_i;
   logic                     rst_i;
   logic                     isolate_i;
   logic                     isolated_o;
   logic                     req_valid_i;
   secsub_pkg::addr_t        req_addr_i;
   secsub_pkg::narrow_data_t req_data_i;
   secsub_pkg::narrow_strb_t req_strb_i;
   logic                     req_ready_o;
   logic                     out_valid_o;
   secsub_pkg::addr_t        out_addr_o;
   secsub_pkg::wide_data_t   out_data_o;
   secsub_pkg::wide_strb_t   out_strb_o;
   logic                     out_ready_i;
   logic                     rsp_valid_i;
   logic                     rsp_err_i;
   logic                     rsp_valid_o;
   logic                     rsp_err_o;

   // Commands from the data file
   logic [7:0]               cmd_q[$];
   secsub_pkg::addr_t        addr_q[$];
   secsub_pkg::narrow_data_t data_q[$];
   secsub_pkg::narrow_strb_t strb_q[$];
   secsub_pkg::wide_strb_t   wstrb_q[$];
   int                       srcline_q[$];

   // Outstanding expectations
   secsub_pkg::addr_t        exp_addr_q[$];
   secsub_pkg::wide_data_t   exp_data_q[$];
   secsub_pkg::wide_strb_t   exp_strb_q[$];
   int                       exp_line_q[$];
   logic                     rsp_exp_q[$];
   int                       rsp_line_q[$];

   int          value_errors = 0;
   int          other_errors = 0;
   int          cycle_cnt = 0;
   int          limit_cycles = 0;
   int          pend_fwd = 0;
   int          fd;
   logic        iso_mode = 1'b1;
   logic        isolated_prev = 1'b1;
   logic        fire_seen = 1'b0;
   logic        rsp_stage = 1'b0;
   logic [15:0] lfsr = 16'd18242;

   secure_subsystem_wrap secure_subsystem_wrap_i (
      .clk_i       ( clk_i       ),
      .rst_i       ( rst_i       ),
      .isolate_i   ( isolate_i   ),
      .isolated_o  ( isolated_o  ),
      .req_valid_i ( req_valid_i ),
      .req_addr_i  ( req_addr_i  ),
      .req_data_i  ( req_data_i  ),
      .req_strb_i  ( req_strb_i  ),
      .req_ready_o ( req_ready_o ),
      .out_valid_o ( out_valid_o ),
      .out_addr_o  ( out_addr_o  ),
      .out_data_o  ( out_data_o  ),
      .out_strb_o  ( out_strb_o  ),
      .out_ready_i ( out_ready_i ),
      .rsp_valid_i ( rsp_valid_i ),
      .rsp_err_i   ( rsp_err_i   ),
      .rsp_valid_o ( rsp_valid_o ),
      .rsp_err_o   ( rsp_err_o   )
   );

   always #4 clk_i = ~clk_i;

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic report_mismatch(input string name, input int line,
                                  input logic [63:0] expected, input logic [63:0] actual);
      $display("[FAIL] %s (line %0d): expected %h, actual %h", name, line, expected, actual);
      value_errors = value_errors + 1;
   endtask

   task automatic report_problem(input string msg);
      $display("Error at cycle %0d: %s", cycle_cnt, msg);
      other_errors = other_errors + 1;
   endtask

   task automatic read_testdata();
      string                    text;
      int                       n;
      int                       line_no;
      logic [7:0]               c;
      secsub_pkg::addr_t        a;
      secsub_pkg::narrow_data_t d;
      secsub_pkg::narrow_strb_t s;
      secsub_pkg::wide_strb_t   e;
      line_no = 0;
      while (!$feof(fd)) begin
         n = $fgets(text, fd);
         line_no = line_no + 1;
         if (n > 0 && text.getc(0) != "#") begin
            n = $sscanf(text, "%c %h %h %h %h", c, a, d, s, e);
            if (n == 5) begin
               cmd_q.push_back(c);
               addr_q.push_back(a);
               data_q.push_back(d);
               strb_q.push_back(s);
               wstrb_q.push_back(e);
               srcline_q.push_back(line_no);
            end
         end
      end
      $fclose(fd);
   endtask

   // Isolation rises while the last forwarded write may still be in flight
   // Terminated writes are answered before it falls
   task automatic set_isolation(input logic level);
      if (!level) begin
         while (rsp_exp_q.size() != 0) @(negedge clk_i);
      end
      @(posedge clk_i);
      isolate_i <= level;
      @(negedge clk_i);
      while (isolated_o !== level) @(negedge clk_i);
      iso_mode = level;
   endtask

   task automatic send_write(input int idx);
      int line;
      line = srcline_q[idx];
      if (iso_mode) begin
         rsp_exp_q.push_back(1'b1);
         rsp_line_q.push_back(line);
      end else begin
         exp_addr_q.push_back(addr_q[idx]);
         exp_data_q.push_back({data_q[idx], data_q[idx]});
         exp_strb_q.push_back(wstrb_q[idx]);
         exp_line_q.push_back(line);
         rsp_exp_q.push_back(1'b0);
         rsp_line_q.push_back(line);
      end
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_addr_i  <= addr_q[idx];
      req_data_i  <= data_q[idx];
      req_strb_i  <= strb_q[idx];
      @(negedge clk_i);
      while (!req_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      req_valid_i <= 1'b0;
   endtask

   task automatic run_tests();
      int i;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      if (isolated_o !== 1'b1) report_mismatch("reset isolated_o", 0, 64'(1), 64'(isolated_o));
      if (out_valid_o !== 1'b0) report_mismatch("reset out_valid_o", 0, 64'(0), 64'(out_valid_o));
      if (rsp_valid_o !== 1'b0) report_mismatch("reset rsp_valid_o", 0, 64'(0), 64'(rsp_valid_o));
      if (req_ready_o !== 1'b1) report_mismatch("reset req_ready_o", 0, 64'(1), 64'(req_ready_o));
      set_isolation(1'b0);
      for (i = 0; i < cmd_q.size(); i++) begin
         if (cmd_q[i] == "I") begin
            set_isolation(addr_q[i][0]);
         end else if (cmd_q[i] == "W") begin
            send_write(i);
         end else begin
            report_problem($sformatf("unknown command on line %0d", srcline_q[i]));
         end
      end
      while (exp_addr_q.size() != 0 || rsp_exp_q.size() != 0) @(negedge clk_i);
      // Room for any stray response
      repeat (6) @(negedge clk_i);
   endtask

   // Downstream slave: random ready, response two cycles after acceptance
   always @(posedge clk_i) begin
      out_ready_i <= lfsr[15];
      lfsr        <= lfsr_next(lfsr);
      rsp_stage   <= fire_seen;
      rsp_valid_i <= rsp_stage;
      rsp_err_i   <= 1'b0;
   end

   // Monitors sample mid-cycle, where every output is settled
   always @(negedge clk_i) begin
      fire_seen = out_valid_o && out_ready_i;
      if (!rst_i) begin
         if (out_valid_o && (isolated_o || iso_mode)) begin
            report_problem("outbound write seen while isolated");
         end
         if (fire_seen) begin
            if (exp_addr_q.size() == 0) begin
               report_problem("outbound write with none expected");
            end else begin
               if (out_addr_o !== exp_addr_q[0])
                  report_mismatch("lane addr", exp_line_q[0], 64'(exp_addr_q[0]), 64'(out_addr_o));
               if (out_data_o !== exp_data_q[0])
                  report_mismatch("lane data", exp_line_q[0], exp_data_q[0], out_data_o);
               if (out_strb_o !== exp_strb_q[0])
                  report_mismatch("lane strobe", exp_line_q[0], 64'(exp_strb_q[0]), 64'(out_strb_o));
               void'(exp_addr_q.pop_front());
               void'(exp_data_q.pop_front());
               void'(exp_strb_q.pop_front());
               void'(exp_line_q.pop_front());
               pend_fwd = pend_fwd + 1;
            end
         end
         if (rsp_valid_o) begin
            if (rsp_exp_q.size() == 0) begin
               report_problem("response with no write outstanding");
            end else begin
               if (rsp_err_o !== rsp_exp_q[0])
                  report_mismatch("response err", rsp_line_q[0], 64'(rsp_exp_q[0]), 64'(rsp_err_o));
               if (!rsp_exp_q[0]) pend_fwd = pend_fwd - 1;
               void'(rsp_exp_q.pop_front());
               void'(rsp_line_q.pop_front());
            end
         end
         if (isolated_o && !isolated_prev && pend_fwd != 0) begin
            report_problem("isolated_o rose with forwarded writes still pending");
         end
         isolated_prev = isolated_o;
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (limit_cycles > 0 && cycle_cnt >= limit_cycles) begin
         $display("Timeout: run stopped after %0d cycles", cycle_cnt);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      clk_i       = 1'b0;
      rst_i       = 1'b1;
      isolate_i   = 1'b1;
      req_valid_i = 1'b0;
      req_addr_i  = '0;
      req_data_i  = '0;
      req_strb_i  = '0;
      out_ready_i = 1'b0;
      rsp_valid_i = 1'b0;
      rsp_err_i   = 1'b0;
      fd = $fopen("secsub_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open secsub_testdata.txt");
         $display("ERRORS FOUND");
         $finish;
      end else begin
         read_testdata();
         limit_cycles = 40 * cmd_q.size() + 100;
         run_tests();
         $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
         if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
         end else begin
            $display("ERRORS FOUND");
         end
         $finish;
      end
   end

endmodule
